/* design/i2s_rx_pkg.sv */
package i2s_rx_pkg;

	// ********************
	// host word format
	// ********************

	// width of the word returned to the host
	localparam int RDATA_WIDTH = 32;

	// lane id sits in the top bits of the host word
	localparam int ID_WIDTH = 5;

	// bit clocks in one half frame of the serial link
	localparam int SLOT_BITS = 32;

	// ********************
	// enums
	// ********************

	// channel follows the word select level on the wire
	typedef enum logic {
		CHAN_LEFT  = 1'b0,
		CHAN_RIGHT = 1'b1
	} chan_t;

	// DS_SKIP covers the one bit delay between a word select change and the MSB
	typedef enum logic [1:0] {
		DS_WAIT_EDGE = 2'd0,
		DS_SKIP      = 2'd1,
		DS_SHIFT     = 2'd2,
		DS_IDLE_PAD  = 2'd3
	} deser_state_t;

endpackage

/* design/i2s_lane_if.sv */
`timescale 1ns/1ps

// one serial lane after synchronization where every field updates on a bit clock rise
interface i2s_lane_if;

	logic bclk_rise;
	logic ws;
	logic ws_change;
	logic sd;

	modport sync (
		output bclk_rise,
		output ws,
		output ws_change,
		output sd
	);

	modport rx (
		input bclk_rise,
		input ws,
		input ws_change,
		input sd
	);

endinterface

/* design/lane_rd_if.sv */
`timescale 1ns/1ps

// head_word is valid whenever ready is high
interface lane_rd_if import i2s_rx_pkg::*; ();

	logic                   rd_en;
	logic [RDATA_WIDTH-1:0] head_word;
	logic                   ready;
	logic                   full_err;
	logic                   empty_err;

	modport host (
		output rd_en,
		input  head_word,
		input  ready,
		input  full_err,
		input  empty_err
	);

	modport lane (
		input  rd_en,
		output head_word,
		output ready,
		output full_err,
		output empty_err
	);

endinterface

/* design/i2s_input_sync.sv */
`timescale 1ns/1ps

module i2s_input_sync #(
	parameter int NUM_LANES = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [NUM_LANES-1:0] bclk,
	input  logic [NUM_LANES-1:0] lrclk,
	input  logic [NUM_LANES-1:0] sdata,
	i2s_lane_if.sync             lanes [NUM_LANES]
);

	logic [NUM_LANES-1:0] bclk_s1;
	logic [NUM_LANES-1:0] bclk_s2;
	logic [NUM_LANES-1:0] bclk_d;
	logic [NUM_LANES-1:0] lr_s1;
	logic [NUM_LANES-1:0] lr_s2;
	logic [NUM_LANES-1:0] sd_s1;
	logic [NUM_LANES-1:0] sd_s2;
	logic [NUM_LANES-1:0] rise_q;
	logic [NUM_LANES-1:0] ws_q;
	logic [NUM_LANES-1:0] ws_change_q;
	logic [NUM_LANES-1:0] sd_q;

	// all three pins go through the same depth so they stay aligned
	always_ff @(posedge clk) begin
		if (!rst) begin
			bclk_s1     <= '0;
			bclk_s2     <= '0;
			bclk_d      <= '0;
			lr_s1       <= '0;
			lr_s2       <= '0;
			sd_s1       <= '0;
			sd_s2       <= '0;
			rise_q      <= '0;
			ws_q        <= '0;
			ws_change_q <= '0;
			sd_q        <= '0;
		end else begin
			bclk_s1 <= bclk;
			bclk_s2 <= bclk_s1;
			bclk_d  <= bclk_s2;
			lr_s1   <= lrclk;
			lr_s2   <= lr_s1;
			sd_s1   <= sdata;
			sd_s2   <= sd_s1;
			rise_q  <= bclk_s2 & ~bclk_d;
			for (int i = 0; i < NUM_LANES; i++) begin
				if (bclk_s2[i] && !bclk_d[i]) begin
					ws_q[i]        <= lr_s2[i];
					sd_q[i]        <= sd_s2[i];
					ws_change_q[i] <= lr_s2[i] ^ ws_q[i];
				end else begin
					ws_change_q[i] <= 1'b0;
				end
			end
		end
	end

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		assign lanes[g].bclk_rise = rise_q[g];
		assign lanes[g].ws        = ws_q[g];
		assign lanes[g].ws_change = ws_change_q[g];
		assign lanes[g].sd        = sd_q[g];

		// the bit clock has to stay below clk/4 for the two flop synchronizer
		a_bclk_rate: assert property (@(posedge clk) disable iff (!rst)
			rise_q[g] |=> !rise_q[g] [*3]);
	end

endmodule

/* design/i2s_deserializer.sv */
`timescale 1ns/1ps

module i2s_deserializer import i2s_rx_pkg::*; #(
	parameter int SAMPLE_WIDTH = 24
) (
	input  logic                    clk,
	input  logic                    rst,
	i2s_lane_if.rx                  lane,
	output logic                    done,
	output chan_t                   chan,
	output logic [SAMPLE_WIDTH-1:0] sample
);

	localparam int CNT_W = $clog2(SLOT_BITS);

	deser_state_t     state;
	logic [CNT_W-1:0] bit_cnt;
	logic             take_bit;

	// a bit is taken on every rise after the delay slot until the sample is complete
	assign take_bit = lane.bclk_rise && !lane.ws_change &&
		(state == DS_SKIP || state == DS_SHIFT);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state   <= DS_WAIT_EDGE;
			bit_cnt <= '0;
			chan    <= CHAN_LEFT;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (lane.bclk_rise) begin
				if (lane.ws_change) begin
					// the bit seen with the change is the I2S delay bit
					// a sample still in progress is dropped here
					chan    <= chan_t'(lane.ws);
					bit_cnt <= '0;
					state   <= DS_SKIP;
				end else begin
					case (state)
						DS_SKIP, DS_SHIFT: begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == CNT_W'(SAMPLE_WIDTH - 1)) begin
								done  <= 1'b1;
								state <= DS_IDLE_PAD;
							end else begin
								state <= DS_SHIFT;
							end
						end
						DS_IDLE_PAD: begin
							bit_cnt <= bit_cnt + 1'b1;
							// slot overran without a word select change, so resync
							if (bit_cnt == CNT_W'(SLOT_BITS - 1)) begin
								state <= DS_WAIT_EDGE;
							end
						end
						default: begin
							state <= DS_WAIT_EDGE;
						end
					endcase
				end
			end
		end
	end

	// MSB first, so the sample holds still while done is high
	always_ff @(posedge clk) begin
		if (take_bit) begin
			sample <= {sample[SAMPLE_WIDTH-2:0], lane.sd};
		end
	end

endmodule

/* design/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 25
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             not_empty,
	output logic             full_err,
	output logic             empty_err
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             do_wr;
	logic             do_rd;

	assign do_rd = rd_en && (count != '0);
	// a pop in the same cycle frees the slot for a write into a full buffer
	assign do_wr = wr_en && ((count != FULL_COUNT) || do_rd);

	assign rd_data   = mem[rd_ptr];
	assign not_empty = (count != '0);

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			full_err  <= 1'b0;
			empty_err <= 1'b0;
		end else begin
			full_err  <= wr_en && !do_wr;
			empty_err <= rd_en && !do_rd;
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_count_range: assert property (@(posedge clk) disable iff (!rst)
		count <= FULL_COUNT);

endmodule

/* design/i2s_channel.sv */
`timescale 1ns/1ps

module i2s_channel import i2s_rx_pkg::*; #(
	parameter int LANE_ID      = 0,
	parameter int FIFO_DEPTH   = 8,
	parameter int SAMPLE_WIDTH = 24
) (
	input  logic                    clk,
	input  logic                    rst,
	i2s_lane_if.rx                  lane,
	lane_rd_if.lane                 rd,
	output logic                    word_valid,
	output chan_t                   word_chan,
	output logic [SAMPLE_WIDTH-1:0] word_sample
);

	logic                    done;
	chan_t                   chan;
	logic [SAMPLE_WIDTH-1:0] sample;
	logic [SAMPLE_WIDTH:0]   wr_word;
	logic [SAMPLE_WIDTH:0]   head;

	i2s_deserializer #(
		.SAMPLE_WIDTH(SAMPLE_WIDTH)
	) u_deser (
		.clk    (clk),
		.rst    (rst),
		.lane   (lane),
		.done   (done),
		.chan   (chan),
		.sample (sample)
	);

	// the id is constant per lane, so only channel and sample are buffered
	assign wr_word = {chan, sample};

	sample_fifo #(
		.DEPTH (FIFO_DEPTH),
		.WIDTH (SAMPLE_WIDTH + 1)
	) u_fifo (
		.clk       (clk),
		.rst       (rst),
		.wr_en     (done),
		.wr_data   (wr_word),
		.rd_en     (rd.rd_en),
		.rd_data   (head),
		.not_empty (rd.ready),
		.full_err  (rd.full_err),
		.empty_err (rd.empty_err)
	);

	always_comb begin
		rd.head_word = '0;
		rd.head_word[RDATA_WIDTH-1 -: ID_WIDTH] = ID_WIDTH'(LANE_ID);
		rd.head_word[SAMPLE_WIDTH:0] = head;
	end

	assign word_valid  = done;
	assign word_chan   = chan;
	assign word_sample = sample;

endmodule

/* design/read_mux.sv */
`timescale 1ns/1ps

module read_mux import i2s_rx_pkg::*; #(
	parameter int NUM_LANES = 2
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   read_enable,
	input  logic [NUM_LANES-1:0]   chip_select,
	lane_rd_if.host                rd [NUM_LANES],
	output logic [RDATA_WIDTH-1:0] rdata,
	output logic [NUM_LANES-1:0]   output_ready,
	output logic [NUM_LANES-1:0]   buffer_full_error,
	output logic [NUM_LANES-1:0]   buffer_empty_error
);

	logic [RDATA_WIDTH-1:0] head_words [NUM_LANES];
	logic [NUM_LANES-1:0]   sel;
	logic [RDATA_WIDTH-1:0] sel_word;
	logic                   hit;

	assign sel = chip_select & {NUM_LANES{read_enable}};

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		assign rd[g].rd_en           = sel[g];
		assign head_words[g]         = rd[g].head_word;
		assign output_ready[g]       = rd[g].ready;
		assign buffer_full_error[g]  = rd[g].full_err;
		assign buffer_empty_error[g] = rd[g].empty_err;
	end

	// chip_select is one-hot, so an OR of the gated heads is the selected word
	always_comb begin
		sel_word = '0;
		hit      = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (sel[i] && output_ready[i]) begin
				sel_word = sel_word | head_words[i];
				hit      = 1'b1;
			end
		end
	end

	// a read of an empty lane leaves rdata as it was
	always_ff @(posedge clk) begin
		if (!rst) begin
			rdata <= '0;
		end else if (hit) begin
			rdata <= sel_word;
		end
	end

	a_cs_onehot: assert property (@(posedge clk) disable iff (!rst)
		read_enable |-> $onehot(chip_select));

endmodule

/* design/i2s_rx_array.sv */
`timescale 1ns/1ps

module i2s_rx_array import i2s_rx_pkg::*; #(
	parameter int NUM_LANES    = 2,
	parameter int FIFO_DEPTH   = 8,
	parameter int SAMPLE_WIDTH = 24
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [NUM_LANES-1:0]   bclk,
	input  logic [NUM_LANES-1:0]   lrclk,
	input  logic [NUM_LANES-1:0]   sdata,
	input  logic [NUM_LANES-1:0]   chip_select,
	input  logic                   read_enable,
	output logic [NUM_LANES-1:0]   output_ready,
	output logic [NUM_LANES-1:0]   buffer_full_error,
	output logic [NUM_LANES-1:0]   buffer_empty_error,
	output logic [RDATA_WIDTH-1:0] rdata,
	output logic                   s_data_valid,
	output logic [SAMPLE_WIDTH:0]  i2s_received_data
);

	i2s_lane_if lane_bus [NUM_LANES] ();
	lane_rd_if  rd_bus [NUM_LANES] ();

	logic [NUM_LANES-1:0]    word_valid;
	chan_t                   word_chan [NUM_LANES];
	logic [SAMPLE_WIDTH-1:0] word_sample [NUM_LANES];

	i2s_input_sync #(
		.NUM_LANES(NUM_LANES)
	) u_sync (
		.clk   (clk),
		.rst   (rst),
		.bclk  (bclk),
		.lrclk (lrclk),
		.sdata (sdata),
		.lanes (lane_bus)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_chan
		i2s_channel #(
			.LANE_ID      (g),
			.FIFO_DEPTH   (FIFO_DEPTH),
			.SAMPLE_WIDTH (SAMPLE_WIDTH)
		) u_channel (
			.clk         (clk),
			.rst         (rst),
			.lane        (lane_bus[g]),
			.rd          (rd_bus[g]),
			.word_valid  (word_valid[g]),
			.word_chan   (word_chan[g]),
			.word_sample (word_sample[g])
		);
	end

	read_mux #(
		.NUM_LANES(NUM_LANES)
	) u_read_mux (
		.clk                (clk),
		.rst                (rst),
		.read_enable        (read_enable),
		.chip_select        (chip_select),
		.rd                 (rd_bus),
		.rdata              (rdata),
		.output_ready       (output_ready),
		.buffer_full_error  (buffer_full_error),
		.buffer_empty_error (buffer_empty_error)
	);

	// monitor tap on lane 0 is strobed with its FIFO write
	assign s_data_valid      = word_valid[0];
	assign i2s_received_data = {word_chan[0], word_sample[0]};

endmodule

/* dv/i2s_rx_tb.sv */
`timescale 1ns/1ps

module i2s_rx_tb;

	localparam int NUM_LANES    = 2;
	localparam int FIFO_DEPTH   = 8;
	localparam int SAMPLE_WIDTH = 24;
	localparam int CLK_PER_BIT  = 8;
	localparam int SLOT_BITS    = 32;
	localparam int LEAD_BITS    = 4;
	// frames on the wire over all tests where lanes that run together count once
	localparam int TOTAL_FRAMES = 4 + 3 + 5;
	localparam int WATCHDOG_NS  = (TOTAL_FRAMES * 512 + 4000) * 100;

	logic                    clk;
	logic                    rst;
	logic [NUM_LANES-1:0]    bclk;
	logic [NUM_LANES-1:0]    lrclk;
	logic [NUM_LANES-1:0]    sdata;
	logic [NUM_LANES-1:0]    chip_select;
	logic                    read_enable;
	logic [NUM_LANES-1:0]    output_ready;
	logic [NUM_LANES-1:0]    buffer_full_error;
	logic [NUM_LANES-1:0]    buffer_empty_error;
	logic [31:0]             rdata;
	logic                    s_data_valid;
	logic [SAMPLE_WIDTH:0]   i2s_received_data;

	logic [31:0]             lfsr;
	logic [31:0]             exp_q [NUM_LANES][$];
	logic [SAMPLE_WIDTH:0]   mon_q [$];
	logic [SAMPLE_WIDTH:0]   mon_exp;
	logic [31:0]             rd_expected;
	logic [31:0]             saved_rdata;
	logic                    rd_pending;
	logic                    empty_pending;
	int                      rd_lane;
	int                      full_pulses [NUM_LANES];
	int                      error_count;
	int                      seq_error_count;

	i2s_rx_array #(
		.NUM_LANES    (NUM_LANES),
		.FIFO_DEPTH   (FIFO_DEPTH),
		.SAMPLE_WIDTH (SAMPLE_WIDTH)
	) UUT (
		.clk                (clk),
		.rst                (rst),
		.bclk               (bclk),
		.lrclk              (lrclk),
		.sdata              (sdata),
		.chip_select        (chip_select),
		.read_enable        (read_enable),
		.output_ready       (output_ready),
		.buffer_full_error  (buffer_full_error),
		.buffer_empty_error (buffer_empty_error),
		.rdata              (rdata),
		.s_data_valid       (s_data_valid),
		.i2s_received_data  (i2s_received_data)
	);

	always #50 clk = ~clk;

	// ********************
	// reference model
	// ********************

	// taps 32, 22, 2 and 1 give a maximal length sequence
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// lane id on top and the channel just above the sample with zeros between
	function automatic logic [31:0] expected_word(input int lane, input logic chan,
		input logic [SAMPLE_WIDTH-1:0] sample);
		logic [31:0] w;
		w = '0;
		w[31:27] = lane[4:0];
		w[SAMPLE_WIDTH] = chan;
		w[SAMPLE_WIDTH-1:0] = sample;
		return w;
	endfunction

	task automatic draw_sample(output logic [SAMPLE_WIDTH-1:0] s);
		for (int i = 0; i < SAMPLE_WIDTH; i++) begin
			lfsr = lfsr_next(lfsr);
			s = {s[SAMPLE_WIDTH-2:0], lfsr[0]};
		end
	endtask

	// ********************
	// serial source and host reads
	// ********************

	// word select and data change while the bit clock is low
	task automatic drive_bit(input int lane, input logic ws, input logic bit_val);
		@(posedge clk);
		bclk[lane]  <= 1'b0;
		lrclk[lane] <= ws;
		sdata[lane] <= bit_val;
		repeat (CLK_PER_BIT / 2) @(posedge clk);
		bclk[lane] <= 1'b1;
		repeat (CLK_PER_BIT / 2 - 1) @(posedge clk);
	endtask

	task automatic send_frames(input int lane, input int frames);
		logic [SAMPLE_WIDTH-1:0] smp [$];
		logic [SAMPLE_WIDTH-1:0] s;
		logic                    ch;
		logic                    bit_val;
		for (int i = 0; i < 2 * frames; i++) begin
			draw_sample(s);
			ch = i[0];
			smp.push_back(s);
			exp_q[lane].push_back(expected_word(lane, ch, s));
			if (lane == 0) begin
				mon_q.push_back({ch, s});
			end
		end
		// a short right slot first, so the left slot starts on a word select change
		for (int b = 0; b < LEAD_BITS; b++) begin
			drive_bit(lane, 1'b1, 1'b0);
		end
		for (int i = 0; i < 2 * frames; i++) begin
			for (int b = 0; b < SLOT_BITS; b++) begin
				// bit 0 of a slot is the I2S delay bit and the MSB follows it
				bit_val = (b >= 1 && b <= SAMPLE_WIDTH) ? smp[i][SAMPLE_WIDTH-b] : 1'b0;
				drive_bit(lane, i[0], bit_val);
			end
		end
		@(posedge clk);
		bclk[lane] <= 1'b0;
	endtask

	task automatic read_lane(input int lane);
		@(posedge clk);
		read_enable <= 1'b1;
		chip_select <= NUM_LANES'(1 << lane);
		@(posedge clk);
		read_enable <= 1'b0;
		chip_select <= '0;
	endtask

	task automatic drain_lane(input int lane, output int n);
		n = 0;
		@(negedge clk);
		while (output_ready[lane]) begin
			read_lane(lane);
			n++;
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			seq_error_count++;
			$display("[ERROR] %s: expected %h, got %h", name, exp, got);
		end
	endtask

	// ********************
	// checker
	// ********************

	// a read sampled on one edge shows its result on the next
	always @(posedge clk) begin
		if (rd_pending && rdata !== rd_expected) begin
			error_count++;
			$display("[ERROR] rdata: expected %h, got %h", rd_expected, rdata);
		end
		if (empty_pending) begin
			if (buffer_empty_error[rd_lane] !== 1'b1) begin
				error_count++;
				$display("[ERROR] buffer_empty_error[%0d]: expected %h, got %h",
					rd_lane, 1'b1, buffer_empty_error[rd_lane]);
			end
			if (rdata !== saved_rdata) begin
				error_count++;
				$display("[ERROR] rdata: expected %h, got %h", saved_rdata, rdata);
			end
		end
		rd_pending    = 1'b0;
		empty_pending = 1'b0;
		if (rst && read_enable) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				if (chip_select[i]) begin
					rd_lane = i;
				end
			end
			if (output_ready[rd_lane] !== (exp_q[rd_lane].size() != 0)) begin
				error_count++;
				$display("[ERROR] output_ready[%0d]: expected %h, got %h",
					rd_lane, exp_q[rd_lane].size() != 0, output_ready[rd_lane]);
			end
			if (exp_q[rd_lane].size() == 0) begin
				saved_rdata   = rdata;
				empty_pending = 1'b1;
			end else begin
				rd_expected = exp_q[rd_lane].pop_front();
				rd_pending  = 1'b1;
			end
		end
		for (int i = 0; i < NUM_LANES; i++) begin
			if (buffer_full_error[i]) begin
				full_pulses[i]++;
			end
		end
		if (s_data_valid) begin
			if (mon_q.size() == 0) begin
				error_count++;
				$display("s_data_valid pulsed with no sample sent on lane 0");
			end else begin
				mon_exp = mon_q.pop_front();
				if (i2s_received_data !== mon_exp) begin
					error_count++;
					$display("[ERROR] i2s_received_data: expected %h, got %h",
						mon_exp, i2s_received_data);
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int n;
		int full_base;
		clk             = 1'b0;
		rst             = 1'b0;
		bclk            = '0;
		lrclk           = '0;
		sdata           = '0;
		chip_select     = '0;
		read_enable     = 1'b0;
		lfsr            = 32'h17a8_7f44;
		rd_pending      = 1'b0;
		empty_pending   = 1'b0;
		rd_lane         = 0;
		error_count     = 0;
		seq_error_count = 0;
		for (int i = 0; i < NUM_LANES; i++) begin
			full_pulses[i] = 0;
		end
		repeat (3) @(posedge clk);
		rst <= 1'b1;

		// outputs idle after reset
		@(negedge clk);
		expect_value("output_ready", 32'(output_ready), 32'h0);
		expect_value("buffer_full_error", 32'(buffer_full_error), 32'h0);
		expect_value("buffer_empty_error", 32'(buffer_empty_error), 32'h0);
		expect_value("s_data_valid", 32'(s_data_valid), 32'h0);
		expect_value("rdata", rdata, 32'h0);

		// four frames on lane 0 are read back until the lane runs empty
		send_frames(0, 4);
		drain_lane(0, n);
		if (n != 8) begin
			seq_error_count++;
			$display("lane 0 returned %0d words after four frames instead of 8", n);
		end

		// both lanes carry samples at once and the reads alternate between them
		fork
			send_frames(0, 3);
			send_frames(1, 3);
		join
		for (int i = 0; i < 6; i++) begin
			read_lane(0);
			read_lane(1);
		end
		repeat (2) @(negedge clk);
		expect_value("output_ready", 32'(output_ready), 32'h0);

		// ten samples into a buffer of eight drop the last two
		full_base = full_pulses[1];
		send_frames(1, 5);
		repeat (4) @(negedge clk);
		if (full_pulses[1] - full_base != 2) begin
			seq_error_count++;
			$display("lane 1 gave %0d full pulses for two dropped samples",
				full_pulses[1] - full_base);
		end
		while (exp_q[1].size() > FIFO_DEPTH) begin
			void'(exp_q[1].pop_back());
		end
		drain_lane(1, n);
		if (n != FIFO_DEPTH) begin
			seq_error_count++;
			$display("lane 1 returned %0d words from a full buffer instead of 8", n);
		end

		// a read of an empty lane must pulse its error and leave rdata alone
		read_lane(0);
		repeat (3) @(negedge clk);

		if (exp_q[0].size() != 0 || exp_q[1].size() != 0 || mon_q.size() != 0) begin
			seq_error_count++;
			$display("samples were sent that never came back");
		end
		$display("errors: %0d (checker %0d, sequence %0d)",
			error_count + seq_error_count, error_count, seq_error_count);
		if (error_count + seq_error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* i2s_rx_array.f */
design/i2s_rx_pkg.sv
design/i2s_lane_if.sv
design/lane_rd_if.sv
design/i2s_input_sync.sv
design/i2s_deserializer.sv
design/sample_fifo.sv
design/i2s_channel.sv
design/read_mux.sv
design/i2s_rx_array.sv
dv/i2s_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module i2s_rx_tb -f i2s_rx_array.f

out=$(./obj_dir/Vi2s_rx_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi
